//--- softmax_defs.svh
// Softmax sizing and Q16.16 fixed-point constants

`ifndef SOFTMAX_DEFS_SVH
`define SOFTMAX_DEFS_SVH

// Word format
`define WIDTH 32
`define FRAC 16

// Vector shape, element 0 in the top chunk of a tile
`define TILE_SIZE 4
`define TOTAL_ELEMENTS 32

// Fixed-point constants in Q16.16
`define ONE_Q 32'sh0001_0000
`define LOG2E_Q 32'sh0001_7154    // log2(e) ~ 1.442695
`define LN2_Q 32'sh0000_B172      // ln(2) ~ 0.693147

// Sum of up to 32 values of at most 1.0
`define SUM_WIDTH (`WIDTH + 6)

`endif

//--- softmax_pkg.sv
// Softmax shared types for fixed-point words, tiles, exponent split and pass tag
`default_nettype none
`include "softmax_defs.svh"

package softmax_pkg;

    // Signed Q16.16 element
    typedef logic signed [`WIDTH-1:0] fix_t;

    // One tile, index 0 sits in the most significant chunk
    typedef fix_t [0:`TILE_SIZE-1] tile_t;

    // Base-2 exponent, read either as one signed value or as integer over fraction
    typedef union packed {
        logic signed [`WIDTH-1:0] raw;
        struct packed {
            logic signed [`WIDTH-`FRAC-1:0] ipart;   // floor of the exponent
            logic [`FRAC-1:0]               fpart;   // Always positive remainder
        } split;
    } exp_arg_u;

    // Which pass a lane word belongs to
    typedef enum logic {
        PASS_SUM  = 1'b0,
        PASS_NORM = 1'b1
    } pass_t;

endpackage

`default_nettype wire

//--- exp_lane_if.sv
// Exponential lane bus carrying one element with its pass tag in and one result out
`timescale 1ns/10ps
`default_nettype none

interface exp_lane_if import softmax_pkg::*; ();

    // Feeder to lane
    logic  arg_valid;
    fix_t  arg;
    pass_t arg_pass;
    logic  arg_last;     // Last tile of the pass

    // Lane to drain, two cycles behind the argument
    logic  res_valid;
    fix_t  res;
    pass_t res_pass;
    logic  res_last;

    modport feeder (
        output arg_valid, arg, arg_pass, arg_last
    );

    modport lane (
        input  arg_valid, arg, arg_pass, arg_last,
        output res_valid, res, res_pass, res_last
    );

    modport drain (
        input res_valid, res, res_pass, res_last
    );

endinterface

`default_nettype wire

//--- tile_feeder.sv
// Softmax feeder with pass FSM, tile buffer, running maximum and lane argument issue
`timescale 1ns/10ps
`default_nettype none
`include "softmax_defs.svh"

module tile_feeder import softmax_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  tile_t      x_tile,
    input  logic       tile_in_valid,
    input  fix_t       ln_sum,
    input  logic       ln_valid,
    output logic       phase_done,
    exp_lane_if.feeder lanes [`TILE_SIZE]
);
    localparam int NUM_TILES = `TOTAL_ELEMENTS / `TILE_SIZE;
    localparam int ADDRW     = $clog2(NUM_TILES);

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_LOAD    = 3'd1;   // Store tiles, track max
    localparam logic [2:0] S_SUM     = 3'd2;   // Issue x - max
    localparam logic [2:0] S_WAIT_LN = 3'd3;
    localparam logic [2:0] S_NORM    = 3'd4;   // Issue x - max - ln(sum)
    localparam logic [2:0] S_DONE    = 3'd5;

    logic [2:0]       state;
    tile_t            buf_mem [NUM_TILES];
    logic [ADDRW:0]   wr_cnt;                  // Extra bit so an overrun is visible
    logic [ADDRW-1:0] rd_addr;
    logic             start_ok;
    logic             wr_en;
    logic             rd_en;
    logic             rd_last_addr;
    fix_t             max_val;
    fix_t             tile_max;
    fix_t             ln_q;
    fix_t             ln_term;

    // Read stage
    tile_t rd_data;
    logic  rd_vld;
    logic  rd_last;
    pass_t rd_pass;

    // Subtract stage, drives the lanes
    tile_t arg_tile;
    logic  arg_vld;
    logic  arg_last;
    pass_t arg_pass;

    assign start_ok     = start && (state == S_IDLE || state == S_DONE);
    assign wr_en        = (state == S_LOAD) && tile_in_valid;
    assign rd_en        = (state == S_SUM) || (state == S_NORM);
    assign rd_last_addr = (rd_addr == ADDRW'(NUM_TILES - 1));
    assign ln_term      = (rd_pass == PASS_NORM) ? ln_q : '0;

    // Running max folded with the incoming tile
    always_comb begin
        tile_max = max_val;
        for (int k = 0; k < `TILE_SIZE; k++) begin
            if ($signed(x_tile[k]) > tile_max) begin
                tile_max = x_tile[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            wr_cnt  <= '0;
            rd_addr <= '0;
        end else begin
            case (state)
                S_IDLE, S_DONE: begin
                    if (start_ok) begin
                        state  <= S_LOAD;
                        wr_cnt <= '0;
                    end
                end
                S_LOAD: begin
                    if (wr_en) begin
                        wr_cnt <= wr_cnt + 1'b1;
                        if (wr_cnt == NUM_TILES - 1) begin
                            state <= S_SUM;   // Eighth tile goes in this edge
                        end
                    end
                end
                S_SUM, S_NORM: begin
                    rd_addr <= rd_last_addr ? '0 : rd_addr + 1'b1;
                    if (rd_last_addr) begin
                        state <= (state == S_SUM) ? S_WAIT_LN : S_DONE;
                    end
                end
                S_WAIT_LN: begin
                    if (ln_valid) begin
                        state <= S_NORM;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Tile buffer, one write and one read port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            buf_mem[wr_cnt[ADDRW-1:0]] <= x_tile;
        end
        rd_data <= buf_mem[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            max_val <= {1'b1, {(`WIDTH-1){1'b0}}};   // Most negative word
        end else if (wr_en) begin
            max_val <= tile_max;
        end
        if (ln_valid) begin
            ln_q <= ln_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_vld     <= 1'b0;
            arg_vld    <= 1'b0;
            phase_done <= 1'b0;
        end else begin
            rd_vld     <= rd_en;
            arg_vld    <= rd_vld;
            phase_done <= rd_vld && rd_last && (rd_pass == PASS_NORM);
        end
    end

    always_ff @(posedge clk) begin
        rd_last  <= rd_last_addr;
        rd_pass  <= (state == S_NORM) ? PASS_NORM : PASS_SUM;
        arg_last <= rd_last;
        arg_pass <= rd_pass;
        for (int k = 0; k < `TILE_SIZE; k++) begin
            arg_tile[k] <= rd_data[k] - max_val - ln_term;
        end
    end

    // Element k of each tile goes to lane k
    for (genvar g = 0; g < `TILE_SIZE; g++) begin : g_lane_drv
        assign lanes[g].arg_valid = arg_vld;
        assign lanes[g].arg       = arg_tile[g];
        assign lanes[g].arg_pass  = arg_pass;
        assign lanes[g].arg_last  = arg_last;
    end

    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> (wr_cnt < NUM_TILES))
        else $error("tile buffer written past its depth");

    a_ln_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        ln_valid |-> (state == S_WAIT_LN))
        else $error("ln_valid outside WAIT_LN");

endmodule

`default_nettype wire

//--- exp_lane.sv
// Two-stage base-2 exponential approximation for one Q16.16 element
`timescale 1ns/10ps
`default_nettype none
`include "softmax_defs.svh"

module exp_lane import softmax_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    exp_lane_if.lane io
);
    logic signed [2*`WIDTH-1:0] prod;
    exp_arg_u                   arg_q;     // x * log2(e)
    logic                       v1;
    logic                       last1;
    pass_t                      pass1;
    logic signed [15:0]         neg_int;
    logic [`WIDTH-1:0]          mant;
    fix_t                       pow2;

    assign prod = io.arg * `LOG2E_Q;

    // Stage one, scale to base 2
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v1 <= 1'b0;
        end else begin
            v1 <= io.arg_valid;
        end
    end

    always_ff @(posedge clk) begin
        arg_q.raw <= prod[`FRAC +: `WIDTH];   // Arithmetic >>> 16, kept to one word
        pass1     <= io.arg_pass;
        last1     <= io.arg_last;
    end

    // Stage two, 2^i * (1 + f) with i <= 0
    assign neg_int = -arg_q.split.ipart;
    assign mant    = {{(`WIDTH-`FRAC-1){1'b0}}, 1'b1, arg_q.split.fpart};

    always_comb begin
        if (!arg_q.split.ipart[15]) begin
            pow2 = `ONE_Q;                    // Only reached for a zero argument
        end else if (arg_q.split.ipart < -16'sd16) begin
            pow2 = '0;                        // Shifted out entirely
        end else begin
            pow2 = mant >> neg_int[4:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            io.res_valid <= 1'b0;
        end else begin
            io.res_valid <= v1;
        end
    end

    always_ff @(posedge clk) begin
        io.res      <= pow2;
        io.res_pass <= pass1;
        io.res_last <= last1;
    end

    a_fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
        io.res_valid == $past(io.arg_valid, 2))
        else $error("exp lane latency is not two cycles");

endmodule

`default_nettype wire

//--- norm_drain.sv
// Softmax drain with exponent sum, leading-one logarithm and output tile assembly
`timescale 1ns/10ps
`default_nettype none
`include "softmax_defs.svh"

module norm_drain import softmax_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      phase_done,
    exp_lane_if.drain lanes [`TILE_SIZE],
    output fix_t      ln_sum,
    output logic      ln_valid,
    output tile_t     y_tile,
    output logic      tile_out_valid,
    output logic      done
);
    tile_t                      res_tile;
    logic                       res_vld;
    logic                       res_last;
    pass_t                      res_pass;
    logic [`SUM_WIDTH-1:0]      acc;
    logic [`SUM_WIDTH-1:0]      tile_sum;
    logic                       sum_rdy;       // acc holds the full sum
    int                         lead;          // Position of the top set bit
    logic [`SUM_WIDTH-1:0]      norm_sum;
    logic [`FRAC-1:0]           mant;
    fix_t                       log2_q;
    logic signed [2*`WIDTH-1:0] ln_prod;
    logic                       norm_armed;
    logic                       out_last;
    logic                       ln_seen;

    for (genvar g = 0; g < `TILE_SIZE; g++) begin : g_lane_res
        assign res_tile[g] = lanes[g].res;
    end

    // All lanes run in lockstep, lane 0 carries the control
    assign res_vld  = lanes[0].res_valid;
    assign res_pass = lanes[0].res_pass;
    assign res_last = lanes[0].res_last;

    always_comb begin
        tile_sum = '0;
        for (int k = 0; k < `TILE_SIZE; k++) begin
            tile_sum = tile_sum + {{(`SUM_WIDTH-`WIDTH){1'b0}}, res_tile[k]};
        end
    end

    // log2(s) = (p - 16) + m, then scaled by ln 2
    always_comb begin
        lead = 0;
        for (int b = 0; b < `SUM_WIDTH; b++) begin
            if (acc[b]) begin
                lead = b;
            end
        end
        norm_sum = acc << (`SUM_WIDTH - 1 - lead);
        mant     = norm_sum[`SUM_WIDTH-2 -: `FRAC];
        log2_q   = {16'(lead - `FRAC), mant};
        ln_prod  = log2_q * `LN2_Q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc            <= '0;
            sum_rdy        <= 1'b0;
            ln_valid       <= 1'b0;
            tile_out_valid <= 1'b0;
            done           <= 1'b0;
            norm_armed     <= 1'b0;
            ln_seen        <= 1'b0;
        end else begin
            sum_rdy        <= res_vld && (res_pass == PASS_SUM) && res_last;
            ln_valid       <= sum_rdy;
            tile_out_valid <= res_vld && (res_pass == PASS_NORM);
            if (start) begin
                acc        <= '0;
                done       <= 1'b0;
                norm_armed <= 1'b0;
                ln_seen    <= 1'b0;
            end else begin
                if (res_vld && (res_pass == PASS_SUM)) begin
                    acc <= acc + tile_sum;
                end
                if (phase_done) begin
                    norm_armed <= 1'b1;   // Feeder has issued its final tile
                end
                if (ln_valid) begin
                    ln_seen <= 1'b1;
                end
                if (tile_out_valid && out_last) begin
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sum_rdy) begin
            ln_sum <= ln_prod[`FRAC +: `WIDTH];
        end
        if (res_vld && (res_pass == PASS_NORM)) begin
            y_tile   <= res_tile;
            out_last <= res_last && norm_armed;
        end
    end

    a_out_after_ln: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(tile_out_valid) |-> ln_seen)
        else $error("output tile before ln_valid since start");

endmodule

`default_nettype wire

//--- softmax_top.sv
// Softmax top level joining the feeder, the exponential lanes and the drain
`timescale 1ns/10ps
`default_nettype none
`include "softmax_defs.svh"

module softmax_top import softmax_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic [`TILE_SIZE*`WIDTH-1:0]  x_tile,          // Element 0 in the top chunk
    input  logic                          tile_in_valid,
    output logic [`TILE_SIZE*`WIDTH-1:0]  y_tile,
    output logic                          tile_out_valid,
    output logic                          done
);
    tile_t x_tile_p;
    tile_t y_tile_p;
    fix_t  ln_sum;
    logic  ln_valid;
    logic  phase_done;

    exp_lane_if lane_bus [`TILE_SIZE] ();

    assign x_tile_p = x_tile;
    assign y_tile   = y_tile_p;

    tile_feeder u_feeder (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .x_tile        (x_tile_p),
        .tile_in_valid (tile_in_valid),
        .ln_sum        (ln_sum),
        .ln_valid      (ln_valid),
        .phase_done    (phase_done),
        .lanes         (lane_bus)
    );

    for (genvar g = 0; g < `TILE_SIZE; g++) begin : g_lane
        exp_lane u_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .io    (lane_bus[g])
        );
    end

    norm_drain u_drain (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .phase_done     (phase_done),
        .lanes          (lane_bus),
        .ln_sum         (ln_sum),
        .ln_valid       (ln_valid),
        .y_tile         (y_tile_p),
        .tile_out_valid (tile_out_valid),
        .done           (done)
    );

endmodule

`default_nettype wire

//--- tb_softmax_model.svh
// Softmax testbench model with the LFSR source and bit-exact Q16.16 arithmetic

`ifndef TB_SOFTMAX_MODEL_SVH
`define TB_SOFTMAX_MODEL_SVH

// One step of a 32-bit Galois LFSR, shifting right
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 32'h8020_0003;
    end
    return n;
endfunction

// 2^(a * log2 e) for a <= 0, integer part as a shift and fraction as 1 + f
function automatic fix_t model_exp(input fix_t a);
    logic signed [63:0] scaled;
    fix_t               y;
    int                 int_part;
    int                 frac_part;
    fix_t               r;
    scaled    = a;                          // Sign extended
    scaled    = scaled * `LOG2E_Q;
    y         = fix_t'(scaled >>> `FRAC);
    int_part  = y >>> `FRAC;                // Floor of the base-2 exponent
    frac_part = y & 32'h0000_FFFF;
    if (int_part >= 0) begin
        r = `ONE_Q;
    end else if (-int_part >= 17) begin
        r = '0;
    end else begin
        r = (`ONE_Q + frac_part) >> (-int_part);
    end
    return r;
endfunction

// Natural log of the sum from its leading one and the 16 bits below it
function automatic fix_t model_ln(input logic [`SUM_WIDTH-1:0] s);
    int                 top;
    logic [`FRAC-1:0]   m;
    fix_t               log2_w;
    logic signed [63:0] prod;
    top = 0;
    for (int b = 0; b < `SUM_WIDTH; b++) begin
        if (s[b]) begin
            top = b;
        end
    end
    if (top >= `FRAC) begin
        m = `FRAC'(s >> (top - `FRAC));
    end else begin
        m = `FRAC'(s << (`FRAC - top));
    end
    log2_w = (top - `FRAC) * 65536 + m;
    prod   = log2_w;
    prod   = prod * `LN2_Q;
    return fix_t'(prod >>> `FRAC);
endfunction

// Full softmax over one vector, in input order
function automatic void model_softmax(input fix_t x [`TOTAL_ELEMENTS],
                                      output fix_t y [`TOTAL_ELEMENTS]);
    fix_t                  mx;
    fix_t                  ln;
    logic [`SUM_WIDTH-1:0] sum;
    mx = x[0];
    for (int i = 1; i < `TOTAL_ELEMENTS; i++) begin
        if (x[i] > mx) begin
            mx = x[i];
        end
    end
    sum = '0;
    for (int i = 0; i < `TOTAL_ELEMENTS; i++) begin
        sum = sum + model_exp(x[i] - mx);
    end
    ln = model_ln(sum);
    for (int i = 0; i < `TOTAL_ELEMENTS; i++) begin
        y[i] = model_exp(x[i] - mx - ln);
    end
endfunction

`endif

//--- tb_softmax.sv
// Softmax testbench running random and corner vectors against a bit-exact model
`timescale 1ns/10ps
`default_nettype none
`include "softmax_defs.svh"

module tb_softmax import softmax_pkg::*; ();

    `include "tb_softmax_model.svh"

    localparam int NUM_TILES   = `TOTAL_ELEMENTS / `TILE_SIZE;
    localparam int NUM_RANDOM  = 5;
    localparam int NUM_VECTORS = NUM_RANDOM + 2;     // Plus two corner vectors
    localparam int WATCHDOG_NS = (NUM_VECTORS * 200 + 1000) * 10;

    logic                         clk;
    logic                         rst_n;
    logic                         start;
    logic [`TILE_SIZE*`WIDTH-1:0] x_tile;
    logic                         tile_in_valid;
    logic [`TILE_SIZE*`WIDTH-1:0] y_tile;
    logic                         tile_out_valid;
    logic                         done;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    fix_t        vec   [`TOTAL_ELEMENTS];
    fix_t        exp_y [`TOTAL_ELEMENTS];

    softmax_top UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .x_tile         (x_tile),
        .tile_in_valid  (tile_in_valid),
        .y_tile         (y_tile),
        .tile_out_valid (tile_out_valid),
        .done           (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // n fresh bits, one LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [`TILE_SIZE*`WIDTH-1:0] random_tile();
        logic [`TILE_SIZE*`WIDTH-1:0] t;
        for (int k = 0; k < `TILE_SIZE; k++) begin
            t[k*`WIDTH +: `WIDTH] = take_bits(32);
        end
        return t;
    endfunction

    // Element 0 of the tile goes to the top chunk
    function automatic logic [`TILE_SIZE*`WIDTH-1:0] pack_tile(input int t);
        logic [`TILE_SIZE*`WIDTH-1:0] p;
        for (int k = 0; k < `TILE_SIZE; k++) begin
            p[(`TILE_SIZE-1-k)*`WIDTH +: `WIDTH] = vec[t*`TILE_SIZE + k];
        end
        return p;
    endfunction

    task automatic compare_word(input string what, input logic [31:0] actual,
                                input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic fill_random();
        logic [31:0] r;
        for (int i = 0; i < `TOTAL_ELEMENTS; i++) begin
            r      = take_bits(20);              // About +-8.0
            vec[i] = {{12{r[19]}}, r[19:0]};
        end
    endtask

    task automatic check_idle_after_reset();
        for (int c = 0; c < 20; c++) begin
            @(posedge clk);
            #1;
            x_tile        = random_tile();
            tile_in_valid = ~tile_in_valid;
            @(negedge clk);
            compare_word("tile_out_valid before start", tile_out_valid, 32'd0);
            compare_word("done before start", done, 32'd0);
        end
        @(posedge clk);
        #1;
        tile_in_valid = 1'b0;
    endtask

    task automatic drive_vector(input bit with_gaps);
        int gap;
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        compare_word("done after start", done, 32'd0);
        for (int t = 0; t < NUM_TILES; t++) begin
            gap = with_gaps ? int'(take_bits(2)) : 0;
            repeat (gap) begin
                x_tile        = random_tile();   // Must be ignored
                tile_in_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            x_tile        = pack_tile(t);
            tile_in_valid = 1'b1;
            @(posedge clk);
            #1;
        end
        tile_in_valid = 1'b0;
    endtask

    task automatic collect_outputs(input int v);
        int tiles_seen;
        int idx;
        tiles_seen = 0;
        @(negedge clk);
        while (!tile_out_valid) begin
            @(negedge clk);
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            if (tile_out_valid) begin
                tiles_seen++;
            end
            for (int k = 0; k < `TILE_SIZE; k++) begin
                idx = t*`TILE_SIZE + k;
                compare_word($sformatf("vector %0d y[%0d]", v, idx),
                             y_tile[(`TILE_SIZE-1-k)*`WIDTH +: `WIDTH], exp_y[idx]);
            end
            @(negedge clk);
        end
        compare_word($sformatf("vector %0d output tile count", v), tiles_seen, NUM_TILES);
        compare_word($sformatf("vector %0d tile_out_valid after last", v),
                     tile_out_valid, 32'd0);
        compare_word($sformatf("vector %0d done after last tile", v), done, 32'd1);
    endtask

    task automatic run_vector(input int v, input bit with_gaps);
        model_softmax(vec, exp_y);
        drive_vector(with_gaps);
        collect_outputs(v);
    endtask

    initial begin
        lfsr_state    = 32'h2a93_3873;
        errors        = 0;
        checks        = 0;
        rst_n         = 1'b0;
        start         = 1'b0;
        x_tile        = '0;
        tile_in_valid = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_idle_after_reset();

        // Back-to-back random vectors, gaps from the second one on
        for (int v = 0; v < NUM_RANDOM; v++) begin
            fill_random();
            run_vector(v, v != 0);
        end

        for (int i = 0; i < `TOTAL_ELEMENTS; i++) begin
            vec[i] = 32'sh0001_2345;             // All equal, outputs near 1/32
        end
        run_vector(NUM_RANDOM, 1'b1);

        for (int i = 0; i < `TOTAL_ELEMENTS; i++) begin
            vec[i] = 32'shFFF8_0000;             // -8.0
        end
        vec[13] = 32'sh0007_8000;                // One dominant element
        run_vector(NUM_RANDOM + 1, 1'b0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not complete within %0d ns", WATCHDOG_NS);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
softmax_pkg.sv
exp_lane_if.sv
tile_feeder.sv
exp_lane.sv
norm_drain.sv
softmax_top.sv
tb_softmax.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the softmax testbench with Verilator, run it and report pass or fail

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    -f filelist.f --top-module tb_softmax -o tb_softmax_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/tb_softmax_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" <<< "$sim_out"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi
